// File: compile.f
source/mem_pkg.sv
source/req_buffer.sv
source/mem_arbiter.sv
source/bus_driver.sv
source/load_assembler.sv
source/mem_unit.sv
tests/mem_unit_properties.sv
tests/tb_mem_unit.sv

// File: Makefile
# Verilator simulation of tb_mem_unit; pass is decided from the log
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_unit -f compile.f -o sim_mem_unit
	./obj_dir/sim_mem_unit | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/tb_mem_unit.sv
/* testbench for mem_unit with a byte-wide memory model and an io output queue
   only 0x1000-0x10ff is filled; other addresses read as a fold of the address */
`timescale 1ns/10ps

module tb_mem_unit import mem_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 100;
  localparam int IO_HOLD_CYCLES = 10;
  localparam int N_STEPS        = 20;

  typedef enum logic [1:0] {PORT_FETCH, PORT_LSU, PORT_BOTH} port_e;

  typedef struct packed {
    port_e        port;
    logic [31:0]  addr;
    access_size_e size;
    logic         write;
    logic         sign_ext;
    logic [31:0]  wdata;
    // drop rdy_in in the middle of the access
    logic         pause;
    // io_buffer_full high when the request goes out
    logic         io_hold;
  } step_t;

  logic        clk_in;
  logic        arst_n;
  logic        rdy_in;
  logic        io_buffer_full;
  fetch_req_t  fetch_req;
  logic        fetch_valid;
  logic        fetch_ready;
  logic        fetch_rsp_valid;
  logic [31:0] fetch_rsp_data;
  lsu_req_t    lsu_req;
  logic        lsu_valid;
  logic        lsu_ready;
  logic        lsu_rsp_valid;
  logic [31:0] lsu_rsp_data;
  logic [7:0]  mem_din = 8'h00;
  mem_bus_t    mem_bus;

  logic [7:0]  mem_array [logic [31:0]];
  logic [7:0]  io_queue [$];
  step_t       steps [N_STEPS];

  mem_unit i_dut (
    .clk_in          (clk_in),
    .arst_n          (arst_n),
    .rdy_in          (rdy_in),
    .fetch_req       (fetch_req),
    .fetch_valid     (fetch_valid),
    .fetch_ready     (fetch_ready),
    .fetch_rsp_valid (fetch_rsp_valid),
    .fetch_rsp_data  (fetch_rsp_data),
    .lsu_req         (lsu_req),
    .lsu_valid       (lsu_valid),
    .lsu_ready       (lsu_ready),
    .lsu_rsp_valid   (lsu_rsp_valid),
    .lsu_rsp_data    (lsu_rsp_data),
    .mem_din         (mem_din),
    .mem_bus         (mem_bus),
    .io_buffer_full  (io_buffer_full)
  );

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  function automatic logic [7:0] byte_at(logic [31:0] addr);
    if (mem_array.exists(addr)) begin
      return mem_array[addr];
    end
    return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24];
  endfunction

  // read data comes back on the edge after its address
  always @(posedge clk_in) begin
    mem_din <= byte_at(mem_bus.addr);
    if (mem_bus.wr) begin
      if (mem_bus.addr >= IO_BASE) begin
        io_queue.push_back(mem_bus.dout);
      end else begin
        mem_array[mem_bus.addr] = mem_bus.dout;
      end
    end
  end

  function automatic int byte_count(access_size_e size);
    case (size)
      SIZE_BYTE: return 1;
      SIZE_HALF: return 2;
      default:   return 4;
    endcase
  endfunction

  // little-endian word from the model, then extended by size and sign
  function automatic logic [31:0] expected_load(logic [31:0] addr, access_size_e size,
                                                logic sign_ext);
    logic [31:0] word;
    word = {byte_at(addr + 3), byte_at(addr + 2), byte_at(addr + 1), byte_at(addr)};
    case (size)
      SIZE_BYTE: return {{24{sign_ext & word[7]}}, word[7:0]};
      SIZE_HALF: return {{16{sign_ext & word[15]}}, word[15:0]};
      default:   return word;
    endcase
  endfunction

  task automatic report_fail(string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    assert (got === expected)
      else report_fail($sformatf("MISMATCH %s expected %h got %h", name, expected, got));
  endtask

  task automatic fill_memory();
    logic [31:0] a;
    for (a = 32'h1000; a < 32'h1100; a++) begin
      mem_array[a] = 8'($urandom);
    end
    // negative bytes so sign extension is visible
    mem_array[32'h1010] = mem_array[32'h1010] | 8'h80;
    mem_array[32'h1011] = mem_array[32'h1011] | 8'h80;
    mem_array[32'h1021] = mem_array[32'h1021] | 8'h80;
    mem_array[32'h1023] = mem_array[32'h1023] | 8'h80;
  endtask

  // port, addr, size, write, sign, wdata, pause, io_hold
  task automatic load_table();
    steps[0]  = '{PORT_FETCH, 32'h1000, SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0};
    steps[1]  = '{PORT_FETCH, 32'h1003, SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0};
    steps[2]  = '{PORT_LSU, 32'h1010, SIZE_BYTE, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0};
    steps[3]  = '{PORT_LSU, 32'h1011, SIZE_BYTE, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0};
    steps[4]  = '{PORT_LSU, 32'h1020, SIZE_HALF, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0};
    steps[5]  = '{PORT_LSU, 32'h1022, SIZE_HALF, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0};
    steps[6]  = '{PORT_LSU, 32'h1030, SIZE_WORD, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0};
    steps[7]  = '{PORT_LSU, 32'h1040, SIZE_BYTE, 1'b1, 1'b0, $urandom, 1'b0, 1'b0};
    steps[8]  = '{PORT_LSU, 32'h1040, SIZE_BYTE, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0};
    steps[9]  = '{PORT_LSU, 32'h1050, SIZE_HALF, 1'b1, 1'b0, $urandom, 1'b0, 1'b0};
    steps[10] = '{PORT_LSU, 32'h1050, SIZE_HALF, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0};
    steps[11] = '{PORT_LSU, 32'h1061, SIZE_WORD, 1'b1, 1'b0, $urandom, 1'b0, 1'b0};
    steps[12] = '{PORT_LSU, 32'h1061, SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0};
    steps[13] = '{PORT_LSU, IO_BASE, SIZE_BYTE, 1'b1, 1'b0, $urandom, 1'b0, 1'b1};
    steps[14] = '{PORT_BOTH, 32'h1070, SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0};
    steps[15] = '{PORT_BOTH, 32'h1078, SIZE_BYTE, 1'b1, 1'b0, $urandom, 1'b0, 1'b0};
    steps[16] = '{PORT_LSU, 32'h1080, SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0};
    steps[17] = '{PORT_LSU, 32'h1090, SIZE_WORD, 1'b1, 1'b0, $urandom, 1'b1, 1'b0};
    steps[18] = '{PORT_LSU, 32'h1090, SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0};
    steps[19] = '{PORT_FETCH, 32'h10a0, SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0};
  endtask

  task automatic run_step(step_t s);
    logic [31:0] exp_fetch;
    logic [31:0] exp_lsu;
    logic [7:0]  prior [6];
    logic [7:0]  exp_byte;
    logic        need_fetch;
    logic        need_lsu;
    logic        got_fetch;
    logic        got_lsu;
    logic        fetch_xfer;
    logic        lsu_xfer;
    int          cycles;
    int          i;
    need_fetch = (s.port != PORT_LSU);
    need_lsu   = (s.port != PORT_FETCH);
    exp_lsu    = s.write ? 32'h0 : expected_load(s.addr, s.size, s.sign_ext);
    for (i = 0; i < 6; i++) begin
      prior[i] = byte_at(s.addr + 32'(i) - 1);
    end
    io_queue.delete();
    got_fetch = 1'b0;
    got_lsu   = 1'b0;
    cycles    = 0;
    @(posedge clk_in);
    #1;
    // in a paired step the fetch reads 16 bytes above the load/store
    fetch_req.addr = (s.port == PORT_BOTH) ? s.addr + 32'h10 : s.addr;
    exp_fetch      = expected_load(fetch_req.addr, SIZE_WORD, 1'b0);
    lsu_req        = '{s.addr, s.wdata, s.size, s.write, s.sign_ext};
    fetch_valid    = need_fetch;
    lsu_valid      = need_lsu;
    io_buffer_full = s.io_hold;
    while (!((got_fetch || !need_fetch) && (got_lsu || !need_lsu))) begin
      @(negedge clk_in);
      if (!rdy_in) begin
        assert (!mem_bus.wr && !fetch_rsp_valid && !lsu_rsp_valid)
          else report_fail("bus write or response while rdy_in is low");
      end
      if (io_buffer_full) begin
        assert (io_queue.size() == 0 && !lsu_rsp_valid)
          else report_fail("io write completed while io_buffer_full is high");
      end
      if (lsu_rsp_valid) begin
        assert (need_lsu && !got_lsu) else report_fail("unexpected load/store response");
        check_value("lsu_rsp_data", lsu_rsp_data, exp_lsu);
        got_lsu = 1'b1;
      end
      if (fetch_rsp_valid) begin
        assert (need_fetch && !got_fetch) else report_fail("unexpected fetch response");
        assert (s.port != PORT_BOTH || got_lsu)
          else report_fail("fetch response came before the load/store response");
        check_value("fetch_rsp_data", fetch_rsp_data, exp_fetch);
        got_fetch = 1'b1;
      end
      // valid and ready both high here means a transfer on the coming edge
      fetch_xfer = fetch_valid && fetch_ready;
      lsu_xfer   = lsu_valid && lsu_ready;
      cycles++;
      assert (cycles < TIMEOUT_CYCLES) else report_fail("timeout waiting for a response");
      @(posedge clk_in);
      #1;
      fetch_valid = fetch_valid && !fetch_xfer;
      lsu_valid   = lsu_valid && !lsu_xfer;
      if (s.pause && cycles == 3) begin
        rdy_in = 1'b0;
      end
      if (s.pause && cycles == 8) begin
        rdy_in = 1'b1;
      end
      if (s.io_hold && cycles == IO_HOLD_CYCLES) begin
        io_buffer_full = 1'b0;
      end
    end
    if (s.write && (s.addr < IO_BASE)) begin
      check_value("mem_array below store", 32'(byte_at(s.addr - 1)), 32'(prior[0]));
      for (i = 0; i < 4; i++) begin
        exp_byte = (i < byte_count(s.size)) ? s.wdata[8*i +: 8] : prior[i + 1];
        check_value($sformatf("mem_array[%h]", s.addr + 32'(i)),
                    32'(byte_at(s.addr + 32'(i))), 32'(exp_byte));
      end
    end
    if (s.io_hold) begin
      assert (io_queue.size() == 1) else report_fail("io write did not appear exactly once");
      check_value("io_queue[0]", 32'(io_queue[0]), 32'(s.wdata[7:0]));
    end
  endtask

  initial begin
    int k;
    void'($urandom(32'h51c238b3));
    arst_n         = 1'b0;
    rdy_in         = 1'b1;
    io_buffer_full = 1'b0;
    fetch_req      = '0;
    fetch_valid    = 1'b0;
    lsu_req        = '0;
    lsu_valid      = 1'b0;
    fill_memory();
    load_table();
    repeat (16) @(posedge clk_in);
    #1;
    arst_n = 1'b1;
    @(negedge clk_in);
    assert (fetch_ready && lsu_ready && !mem_bus.wr && !fetch_rsp_valid && !lsu_rsp_valid)
      else report_fail("outputs not idle after reset");
    for (k = 0; k < N_STEPS; k++) begin
      run_step(steps[k]);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

// File: tests/mem_unit_properties.sv
/* concurrent checks bound into mem_unit
   a pause must leave the bus address and write byte where they were */
`timescale 1ns/10ps

module mem_unit_properties import mem_pkg::*; #(
  parameter logic [31:0] IO_BASE = mem_pkg::IO_BASE
) (
  input logic     clk_in,
  input logic     arst_n,
  input logic     rdy_in,
  input logic     io_buffer_full,
  input mem_bus_t mem_bus,
  input logic     fetch_rsp_valid,
  input logic     lsu_rsp_valid
);

  io_write_held: assert property (@(posedge clk_in) disable iff (!arst_n)
    !(mem_bus.wr && (mem_bus.addr >= IO_BASE) && io_buffer_full))
    else $error("write strobe to an io address while io_buffer_full is high");

  rsp_exclusive: assert property (@(posedge clk_in) disable iff (!arst_n)
    !(fetch_rsp_valid && lsu_rsp_valid))
    else $error("fetch and load/store responses high together");

  fetch_rsp_single: assert property (@(posedge clk_in) disable iff (!arst_n)
    fetch_rsp_valid |=> !fetch_rsp_valid)
    else $error("fetch response longer than one cycle");

  lsu_rsp_single: assert property (@(posedge clk_in) disable iff (!arst_n)
    lsu_rsp_valid |=> !lsu_rsp_valid)
    else $error("load/store response longer than one cycle");

  // a paused cycle neither steps the byte index nor loads a new request
  paused_quiet: assert property (@(posedge clk_in) disable iff (!arst_n)
    !rdy_in |=> ($stable(mem_bus.addr) && $stable(mem_bus.dout)))
    else $error("bus address or write byte moved while rdy_in is low");

endmodule

bind mem_unit mem_unit_properties #(.IO_BASE(IO_BASE)) i_props (
  .clk_in          (clk_in),
  .arst_n          (arst_n),
  .rdy_in          (rdy_in),
  .io_buffer_full  (io_buffer_full),
  .mem_bus         (mem_bus),
  .fetch_rsp_valid (fetch_rsp_valid),
  .lsu_rsp_valid   (lsu_rsp_valid)
);

// File: source/mem_unit.sv
/* memory unit between the core requesters and the 8-bit memory bus
   responses are single-cycle pulses and cannot be back-pressured */
`timescale 1ns/10ps

module mem_unit import mem_pkg::*; #(
  parameter logic [31:0] IO_BASE = mem_pkg::IO_BASE
) (
  input  logic       clk_in,
  input  logic       arst_n,
  // pauses the unit when low
  input  logic       rdy_in,
  input  fetch_req_t fetch_req,
  input  logic       fetch_valid,
  output logic       fetch_ready,
  output logic       fetch_rsp_valid,
  output logic [31:0] fetch_rsp_data,
  input  lsu_req_t   lsu_req,
  input  logic       lsu_valid,
  output logic       lsu_ready,
  output logic       lsu_rsp_valid,
  output logic [31:0] lsu_rsp_data,
  input  logic [7:0] mem_din,
  output mem_bus_t   mem_bus,
  input  logic       io_buffer_full
);

  fetch_req_t              fetch_entry;
  lsu_req_t                lsu_entry;
  logic                    fetch_pending;
  logic                    lsu_pending;
  logic                    take_fetch;
  logic                    take_lsu;
  logic                    grant;
  logic                    sel_lsu;
  logic [BYTE_INDEX_W-1:0] byte_index;
  logic                    issue_write;
  logic                    capture;
  logic [BYTE_INDEX_W-1:0] capture_index;
  logic                    finish;
  access_size_e            held_size;
  logic                    held_signed;
  logic [31:0]             rdata;

  req_buffer #(.payload_t(fetch_req_t)) i_fetch_buf (
    .clk_in      (clk_in),
    .arst_n      (arst_n),
    .in_valid    (fetch_valid),
    .in_payload  (fetch_req),
    .in_ready    (fetch_ready),
    .entry_valid (fetch_pending),
    .entry       (fetch_entry),
    .take        (take_fetch)
  );

  req_buffer #(.payload_t(lsu_req_t)) i_lsu_buf (
    .clk_in      (clk_in),
    .arst_n      (arst_n),
    .in_valid    (lsu_valid),
    .in_payload  (lsu_req),
    .in_ready    (lsu_ready),
    .entry_valid (lsu_pending),
    .entry       (lsu_entry),
    .take        (take_lsu)
  );

  mem_arbiter #(.IO_BASE(IO_BASE)) i_arbiter (
    .clk_in          (clk_in),
    .arst_n          (arst_n),
    .rdy_in          (rdy_in),
    .io_buffer_full  (io_buffer_full),
    .fetch_pending   (fetch_pending),
    .lsu_pending     (lsu_pending),
    .lsu_entry       (lsu_entry),
    .take_fetch      (take_fetch),
    .take_lsu        (take_lsu),
    .grant           (grant),
    .sel_lsu         (sel_lsu),
    .byte_index      (byte_index),
    .issue_write     (issue_write),
    .capture         (capture),
    .capture_index   (capture_index),
    .finish          (finish),
    .fetch_rsp_valid (fetch_rsp_valid),
    .lsu_rsp_valid   (lsu_rsp_valid)
  );

  bus_driver i_bus_driver (
    .clk_in      (clk_in),
    .arst_n      (arst_n),
    .grant       (grant),
    .sel_lsu     (sel_lsu),
    .fetch_entry (fetch_entry),
    .lsu_entry   (lsu_entry),
    .byte_index  (byte_index),
    .issue_write (issue_write),
    .mem_bus     (mem_bus),
    .held_size   (held_size),
    .held_signed (held_signed)
  );

  load_assembler i_load_asm (
    .clk_in        (clk_in),
    .arst_n        (arst_n),
    .capture       (capture),
    .capture_index (capture_index),
    .mem_din       (mem_din),
    .finish        (finish),
    .size          (held_size),
    .sign_ext      (held_signed),
    .rdata         (rdata)
  );

  // one result register serves both response ports
  assign fetch_rsp_data = rdata;
  assign lsu_rsp_data   = rdata;

endmodule

// File: source/load_assembler.sv
/* gathers returned bytes into lanes and extends the word on finish
   lanes clear on finish, so a store with no captures reports zero */
`timescale 1ns/10ps

module load_assembler import mem_pkg::*; (
  input  logic                    clk_in,
  input  logic                    arst_n,
  input  logic                    capture,
  input  logic [BYTE_INDEX_W-1:0] capture_index,
  input  logic [7:0]              mem_din,
  input  logic                    finish,
  input  access_size_e            size,
  input  logic                    sign_ext,
  output logic [31:0]             rdata
);

  logic [3:0][7:0] lanes;
  logic [3:0][7:0] merged;
  logic [31:0]     extended;

  // last byte may arrive in the same cycle as finish
  always_comb begin
    merged = lanes;
    if (capture) begin
      merged[capture_index] = mem_din;
    end
  end

  always_comb begin
    case (size)
      SIZE_BYTE: extended = {{24{sign_ext & merged[0][7]}}, merged[0]};
      SIZE_HALF: extended = {{16{sign_ext & merged[1][7]}}, merged[1], merged[0]};
      default:   extended = merged;
    endcase
  end

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      lanes <= '0;
      rdata <= '0;
    end else if (finish) begin
      lanes <= '0;
      rdata <= extended;
    end else if (capture) begin
      lanes[capture_index] <= mem_din;
    end
  end

endmodule

// File: source/bus_driver.sv
/* holds the granted request and forms one bus cycle per byte index
   fetches are forced to an unsigned word access */
`timescale 1ns/10ps

module bus_driver import mem_pkg::*; (
  input  logic                    clk_in,
  input  logic                    arst_n,
  input  logic                    grant,
  input  logic                    sel_lsu,
  input  fetch_req_t              fetch_entry,
  input  lsu_req_t                lsu_entry,
  input  logic [BYTE_INDEX_W-1:0] byte_index,
  input  logic                    issue_write,
  output mem_bus_t                mem_bus,
  output access_size_e            held_size,
  output logic                    held_signed
);

  logic [31:0] held_addr;
  logic [31:0] held_wdata;

  // size and sign steer the load extension
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      held_size   <= SIZE_WORD;
      held_signed <= 1'b0;
    end else if (grant) begin
      held_size   <= sel_lsu ? lsu_entry.size : SIZE_WORD;
      held_signed <= sel_lsu && lsu_entry.sign_ext;
    end
  end

  always_ff @(posedge clk_in) begin
    if (grant) begin
      held_addr  <= sel_lsu ? lsu_entry.addr : fetch_entry.addr;
      held_wdata <= sel_lsu ? lsu_entry.wdata : '0;
    end
  end

  // little-endian: lane n goes to base + n
  always_comb begin
    mem_bus.addr = held_addr + 32'(byte_index);
    mem_bus.dout = held_wdata[byte_index*8 +: 8];
    mem_bus.wr   = issue_write;
  end

endmodule

// File: source/mem_arbiter.sv
/* control FSM of the memory unit: grant, byte count, io stall and pause
   load/store wins over fetch; only one access is on the bus at a time */
`timescale 1ns/10ps

module mem_arbiter import mem_pkg::*; #(
  parameter logic [31:0] IO_BASE = mem_pkg::IO_BASE
) (
  input  logic                    clk_in,
  input  logic                    arst_n,
  input  logic                    rdy_in,
  input  logic                    io_buffer_full,
  input  logic                    fetch_pending,
  input  logic                    lsu_pending,
  input  lsu_req_t                lsu_entry,
  output logic                    take_fetch,
  output logic                    take_lsu,
  output logic                    grant,
  output logic                    sel_lsu,
  output logic [BYTE_INDEX_W-1:0] byte_index,
  output logic                    issue_write,
  output logic                    capture,
  output logic [BYTE_INDEX_W-1:0] capture_index,
  output logic                    finish,
  output logic                    fetch_rsp_valid,
  output logic                    lsu_rsp_valid
);

  typedef enum logic [1:0] {ST_IDLE, ST_XFER, ST_RESP} state_e;

  state_e                  state;
  logic                    held_write;
  logic                    held_io;
  logic                    src_lsu;
  logic [BYTE_INDEX_W-1:0] last_index;
  logic [BYTE_INDEX_W-1:0] lsu_last;
  logic                    issue;
  logic                    last_byte;
  logic                    fetch_rsp_q;
  logic                    lsu_rsp_q;

  assign grant      = (state == ST_IDLE) && rdy_in && (fetch_pending || lsu_pending);
  assign sel_lsu    = lsu_pending;
  assign take_lsu   = grant && lsu_pending;
  assign take_fetch = grant && !lsu_pending;

  always_comb begin
    case (lsu_entry.size)
      SIZE_BYTE: lsu_last = BYTE_INDEX_W'(0);
      SIZE_HALF: lsu_last = BYTE_INDEX_W'(1);
      default:   lsu_last = BYTE_INDEX_W'(3);
    endcase
  end

  // io writes hold off while the uart buffer is full
  assign issue       = (state == ST_XFER) && rdy_in &&
                       !(held_write && held_io && io_buffer_full);
  assign issue_write = issue && held_write;
  assign last_byte   = (byte_index == last_index);
  // reads finish once the last byte is back, writes on the last write cycle
  assign finish      = ((state == ST_RESP) && rdy_in) || (issue_write && last_byte);

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_IDLE;
      byte_index <= '0;
      held_write <= 1'b0;
      held_io    <= 1'b0;
      src_lsu    <= 1'b0;
      last_index <= '0;
    end else if (grant) begin
      state      <= ST_XFER;
      byte_index <= '0;
      held_write <= lsu_pending && lsu_entry.write;
      held_io    <= lsu_pending && (lsu_entry.addr >= IO_BASE);
      src_lsu    <= lsu_pending;
      last_index <= lsu_pending ? lsu_last : BYTE_INDEX_W'(3);
    end else if (issue) begin
      if (!last_byte) begin
        byte_index <= byte_index + 1'b1;
      end else begin
        state <= held_write ? ST_IDLE : ST_RESP;
      end
    end else if ((state == ST_RESP) && rdy_in) begin
      state <= ST_IDLE;
    end
  end

  // read data shows up one cycle after its address, even across a pause
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      capture       <= 1'b0;
      capture_index <= '0;
    end else begin
      capture       <= issue && !held_write;
      capture_index <= byte_index;
    end
  end

  // response pulse waits out a pause
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      fetch_rsp_q <= 1'b0;
      lsu_rsp_q   <= 1'b0;
    end else if (rdy_in) begin
      fetch_rsp_q <= finish && !src_lsu;
      lsu_rsp_q   <= finish && src_lsu;
    end
  end

  assign fetch_rsp_valid = fetch_rsp_q && rdy_in;
  assign lsu_rsp_valid   = lsu_rsp_q && rdy_in;

endmodule

// File: source/req_buffer.sv
/* one-entry request buffer with valid/ready on the input side
   accepts only while empty, so in_ready stays low from each accept until the take */
`timescale 1ns/10ps

module req_buffer #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk_in,
  input  logic     arst_n,
  input  logic     in_valid,
  input  payload_t in_payload,
  output logic     in_ready,
  output logic     entry_valid,
  output payload_t entry,
  input  logic     take
);

  assign in_ready = !entry_valid;

  // occupancy flag
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      entry_valid <= 1'b0;
    end else if (take) begin
      entry_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      entry_valid <= 1'b1;
    end
  end

  // payload held until the arbiter takes it
  always_ff @(posedge clk_in) begin
    if (in_valid && in_ready) begin
      entry <= in_payload;
    end
  end

endmodule

// File: source/mem_pkg.sv
/* shared types and memory map of the byte-serial memory unit
   words are little-endian on an 8-bit bus; the io range starts at IO_BASE */
package mem_pkg;

  // access width of a load/store request
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_e;

  // width of a byte lane index within one word
  parameter int BYTE_INDEX_W = 2;

  // default start of the memory mapped io range
  parameter logic [31:0] IO_BASE = 32'h0003_0000;

  // instruction fetch always reads a full word
  typedef struct packed {
    logic [31:0] addr;
  } fetch_req_t;

  // load or store from the load/store buffer
  typedef struct packed {
    logic [31:0]  addr;
    logic [31:0]  wdata;
    access_size_e size;
    logic         write;
    // only meaningful for byte and half loads
    logic         sign_ext;
  } lsu_req_t;

  // outputs toward the external byte bus
  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  dout;
    // high for a write cycle, low reads
    logic        wr;
  } mem_bus_t;

endpackage
